// ==== regex_accel.f ====
hdl/regex_pkg.sv
hdl/parity_bram.sv
hdl/regex_matcher.sv
hdl/regex_host_ctrl.sv
hdl/regex_top.sv
verif/tb_clock_gen.sv
verif/regex_tb.sv

// ==== Bender.yml ====
package:
  name: regex_accel

sources:
  - files:
      - hdl/regex_pkg.sv
      - hdl/parity_bram.sv
      - hdl/regex_matcher.sv
      - hdl/regex_host_ctrl.sv
      - hdl/regex_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/regex_tb.sv

// ==== verif/regex_tb.sv ====
`timescale 1ns/1ns

module regex_tb;
    import regex_pkg::*;

    localparam int NUM_CASES            = 9;
    localparam int MAX_PROG             = 6;
    localparam int RANDOM_WORDS         = 16;
    localparam int LONG_LEN             = 40;
    localparam int START_TIMEOUT_CYCLES = 16;
    localparam int MATCH_TIMEOUT_CYCLES = 500;
    localparam int CASE_BOUND_CYCLES    = 200;
    // table cases plus reset, random access, long program and rerun
    localparam int WATCHDOG_CYCLES      = (NUM_CASES + 6) * CASE_BOUND_CYCLES;
    localparam int RAND_SEED            = 32'he89c;

    logic      clk;
    logic      reset;
    reg_word_t data_in_register;
    reg_word_t address_register;
    reg_word_t start_cc_pointer_register;
    reg_word_t cmd_register;
    reg_word_t status_register;
    reg_word_t data_o_register;

    // match table
    mem_payload_t case_prog    [NUM_CASES][MAX_PROG];
    string        case_text    [NUM_CASES];
    mem_addr_t    case_ptr     [NUM_CASES];
    reg_word_t    case_expect  [NUM_CASES];
    reg_word_t    case_elapsed [NUM_CASES];

    // every word the host has written
    mem_payload_t shadow [MEM_DEPTH];

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    regex_top dut (
        .clk                       (clk),
        .reset                     (reset),
        .data_in_register          (data_in_register),
        .address_register          (address_register),
        .start_cc_pointer_register (start_cc_pointer_register),
        .cmd_register              (cmd_register),
        .status_register           (status_register),
        .data_o_register           (data_o_register)
    );

    ////////////////////
    // checks

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_status(input reg_word_t actual, input reg_word_t expected,
                                input string what);
        if (actual !== expected)
        begin
            stop_with_failure($sformatf("FAIL at %0t ns: %s, status %0d, expected %0d",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic check_data(input mem_payload_t actual, input mem_payload_t expected,
                              input string what);
        if (actual !== expected)
        begin
            stop_with_failure($sformatf("FAIL at %0t ns: %s, data 0x%04h, expected 0x%04h",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic check_elapsed(input reg_word_t actual, input reg_word_t expected,
                                 input string what);
        if (actual !== expected)
        begin
            stop_with_failure($sformatf("FAIL at %0t ns: %s, count %0d, expected %0d",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic check_elapsed_above(input reg_word_t actual, input reg_word_t floor,
                                       input string what);
        if (!(actual > floor))
        begin
            stop_with_failure($sformatf("FAIL at %0t ns: %s, count %0d, must exceed %0d",
                                        $time, what, actual, floor));
        end
    endtask

    ////////////////////
    // table

    function automatic mem_payload_t encode_instr(input char_t op, input char_t operand);
        return {op, operand};
    endfunction

    task automatic set_case(input int idx, input string text, input mem_addr_t ptr,
                            input reg_word_t expected,
                            input mem_payload_t w0, input mem_payload_t w1,
                            input mem_payload_t w2, input mem_payload_t w3,
                            input mem_payload_t w4, input mem_payload_t w5);
        case_text[idx]    = text;
        case_ptr[idx]     = ptr;
        case_expect[idx]  = expected;
        case_prog[idx][0] = w0;
        case_prog[idx][1] = w1;
        case_prog[idx][2] = w2;
        case_prog[idx][3] = w3;
        case_prog[idx][4] = w4;
        case_prog[idx][5] = w5;
    endtask

    task automatic fill_table();
        // literal hit and miss
        set_case(0, "abc", 11'h100, STATUS_ACCEPTED,
                 encode_instr(OP_CHAR, "a"), encode_instr(OP_CHAR, "b"),
                 encode_instr(OP_CHAR, "c"), encode_instr(OP_ACCEPT, 8'h00), 16'h0, 16'h0);
        set_case(1, "abc", 11'h120, STATUS_REJECTED,
                 encode_instr(OP_CHAR, "a"), encode_instr(OP_CHAR, "x"),
                 encode_instr(OP_ACCEPT, 8'h00), 16'h0, 16'h0, 16'h0);
        // any character, then the end anchor
        set_case(2, "abc", 11'h140, STATUS_ACCEPTED,
                 encode_instr(OP_CHAR, "a"), encode_instr(OP_ANY, 8'h00),
                 encode_instr(OP_CHAR, "c"), encode_instr(OP_END, 8'h00), 16'h0, 16'h0);
        set_case(3, "abc", 11'h160, STATUS_REJECTED,
                 encode_instr(OP_CHAR, "a"), encode_instr(OP_CHAR, "b"),
                 encode_instr(OP_END, 8'h00), 16'h0, 16'h0, 16'h0);
        // string runs out before the program
        set_case(4, "abc", 11'h180, STATUS_REJECTED,
                 encode_instr(OP_CHAR, "a"), encode_instr(OP_CHAR, "b"),
                 encode_instr(OP_CHAR, "c"), encode_instr(OP_CHAR, "d"),
                 encode_instr(OP_ACCEPT, 8'h00), 16'h0);
        set_case(5, "abc", 11'h1a0, STATUS_REJECTED,
                 encode_instr(OP_ANY, 8'h00), encode_instr(OP_ANY, 8'h00),
                 encode_instr(OP_ANY, 8'h00), encode_instr(OP_ANY, 8'h00),
                 encode_instr(OP_ACCEPT, 8'h00), 16'h0);
        // opcode 9 is not defined
        set_case(6, "abc", 11'h1c0, STATUS_REJECTED,
                 encode_instr(OP_CHAR, "a"), encode_instr(8'h09, "b"),
                 encode_instr(OP_ACCEPT, 8'h00), 16'h0, 16'h0, 16'h0);
        set_case(7, "", 11'h7f0, STATUS_ACCEPTED,
                 encode_instr(OP_ACCEPT, 8'h00), 16'h0, 16'h0, 16'h0, 16'h0, 16'h0);
        // anchored at the start only so a prefix is enough
        set_case(8, "abc", 11'h1e0, STATUS_ACCEPTED,
                 encode_instr(OP_CHAR, "a"), encode_instr(OP_CHAR, "b"),
                 encode_instr(OP_ACCEPT, 8'h00), 16'h0, 16'h0, 16'h0);
    endtask

    ////////////////////
    // host register access

    task automatic write_word(input mem_addr_t addr, input mem_payload_t payload);
        reg_word_t noise;
        noise = $urandom;
        @(posedge clk);
        cmd_register     <= CMD_WRITE;
        address_register <= {{(REG_WIDTH-MEM_ADDR_WIDTH){1'b0}}, addr};
        // upper half is not stored
        data_in_register <= {noise[REG_WIDTH-1:MEM_WIDTH], payload};
        @(posedge clk);
        cmd_register <= CMD_NOP;
        shadow[addr] = payload;
    endtask

    task automatic read_word(input mem_addr_t addr, output mem_payload_t payload);
        @(posedge clk);
        cmd_register     <= CMD_READ;
        address_register <= {{(REG_WIDTH-MEM_ADDR_WIDTH){1'b0}}, addr};
        @(posedge clk);
        cmd_register <= CMD_NOP;
        @(negedge clk);
        payload = data_o_register[MEM_WIDTH-1:0];
        // payload is zero-extended to the register width
        check_data(data_o_register[REG_WIDTH-1:MEM_WIDTH], '0,
                   $sformatf("upper half of the word read at 0x%03h", addr));
    endtask

    task automatic read_elapsed(output reg_word_t value);
        @(posedge clk);
        cmd_register <= CMD_READ_ELAPSED;
        @(negedge clk);
        value = data_o_register;
        @(posedge clk);
        cmd_register <= CMD_NOP;
    endtask

    task automatic start_match(input mem_addr_t ptr);
        int cycles;
        cycles = 0;
        @(posedge clk);
        cmd_register              <= CMD_START;
        start_cc_pointer_register <= {{(REG_WIDTH-MEM_ADDR_WIDTH){1'b0}}, ptr};
        @(negedge clk);
        while (status_register !== STATUS_RUNNING && cycles < START_TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            cycles++;
        end
        if (status_register !== STATUS_RUNNING)
        begin
            stop_with_failure("the matcher never took the start command");
        end
        // drop start before the result comes back
        @(posedge clk);
        cmd_register <= CMD_NOP;
    endtask

    task automatic wait_for_result(output reg_word_t result);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (status_register === STATUS_RUNNING && cycles < MATCH_TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            cycles++;
        end
        if (status_register === STATUS_RUNNING)
        begin
            stop_with_failure($sformatf("the match was still running after %0d cycles",
                                        MATCH_TIMEOUT_CYCLES));
        end
        result = status_register;
    endtask

    task automatic run_case(input int idx);
        reg_word_t result;
        reg_word_t elapsed;
        mem_addr_t addr;
        string     text;
        text = case_text[idx];
        addr = '0;
        for (int w = 0; w < MAX_PROG; w++)
        begin
            write_word(addr, case_prog[idx][w]);
            addr = addr + 1'b1;
        end
        addr = case_ptr[idx];
        for (int i = 0; i < text.len(); i++)
        begin
            write_word(addr, {8'h00, text[i]});
            addr = addr + 1'b1;
        end
        write_word(addr, 16'h0000);
        start_match(case_ptr[idx]);
        wait_for_result(result);
        check_status(result, case_expect[idx], $sformatf("case %0d on \"%s\"", idx, text));
        read_elapsed(elapsed);
        check_elapsed_above(elapsed, 32'd0, $sformatf("elapsed count of case %0d", idx));
        case_elapsed[idx] = elapsed;
    endtask

    ////////////////////
    // main sequence

    initial
    begin
        int           seed;
        reg_word_t    noise;
        reg_word_t    elapsed;
        mem_payload_t got;
        mem_addr_t    addr;
        mem_addr_t    str_addr;
        mem_addr_t    long_ptr;
        mem_addr_t    addr_list [RANDOM_WORDS];

        seed = RAND_SEED;
        noise = $urandom(seed);
        cmd_register              <= CMD_NOP;
        data_in_register          <= '0;
        address_register          <= '0;
        start_cc_pointer_register <= '0;
        fill_table();

        wait (reset === 1'b0);
        @(negedge clk);
        check_status(status_register, STATUS_IDLE, "status after reset");
        read_elapsed(elapsed);
        check_elapsed(elapsed, 32'd0, "elapsed count after reset");

        // random words are all written before any is read
        for (int i = 0; i < RANDOM_WORDS; i++)
        begin
            noise = $urandom;
            addr_list[i] = noise[MEM_ADDR_WIDTH-1:0];
            noise = $urandom;
            write_word(addr_list[i], noise[MEM_WIDTH-1:0]);
        end
        for (int i = 0; i < RANDOM_WORDS; i++)
        begin
            read_word(addr_list[i], got);
            check_data(got, shadow[addr_list[i]],
                       $sformatf("read back at 0x%03h", addr_list[i]));
        end

        for (int i = 0; i < NUM_CASES; i++)
        begin
            run_case(i);
        end
        check_elapsed_above(case_elapsed[0], case_elapsed[8], "four instructions against three");
        check_elapsed_above(case_elapsed[2], case_elapsed[3], "four instructions against three");

        // long program of any-character steps
        long_ptr = 11'h400;
        addr = '0;
        repeat (LONG_LEN)
        begin
            write_word(addr, encode_instr(OP_ANY, 8'h00));
            addr = addr + 1'b1;
        end
        write_word(addr, encode_instr(OP_ACCEPT, 8'h00));
        addr = long_ptr;
        repeat (LONG_LEN)
        begin
            noise = $urandom;
            write_word(addr, {8'h00, 8'h21 + noise[5:0]});
            addr = addr + 1'b1;
        end
        write_word(addr, 16'h0000);

        start_match(long_ptr);
        repeat (12) @(negedge clk);
        check_status(status_register, STATUS_RUNNING, "long program before the reset command");
        read_elapsed(elapsed);
        check_elapsed_above(elapsed, 32'd0, "elapsed count while running");
        @(posedge clk);
        cmd_register <= CMD_RESET;
        @(posedge clk);
        cmd_register <= CMD_NOP;
        @(negedge clk);
        check_status(status_register, STATUS_IDLE, "status after the reset command");
        read_elapsed(elapsed);
        check_elapsed(elapsed, 32'd0, "elapsed count after the reset command");

        // program and string must still be there
        addr = '0;
        for (int i = 0; i < 4; i++)
        begin
            read_word(addr, got);
            check_data(got, shadow[addr], $sformatf("program word %0d after reset", i));
            str_addr = long_ptr + addr;
            read_word(str_addr, got);
            check_data(got, shadow[str_addr], $sformatf("string word %0d after reset", i));
            addr = addr + 1'b1;
        end

        // matcher is usable again
        run_case(0);

        $display("*** TEST PASSED ***");
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure($sformatf("timeout: the run did not finish within %0d clock cycles",
                                    WATCHDOG_CYCLES));
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    localparam int HALF_PERIOD_NS = 4;
    localparam int RESET_CYCLES   = 8;

    // 8 ns period
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #HALF_PERIOD_NS clk = ~clk;
        end
    end

    // synchronous reset, released on a rising edge
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== hdl/regex_top.sv ====
`timescale 1ns/1ns

module regex_top (
    input  logic                 clk,
    input  logic                 reset,
    input  regex_pkg::reg_word_t data_in_register,
    input  regex_pkg::reg_word_t address_register,
    input  regex_pkg::reg_word_t start_cc_pointer_register,
    input  regex_pkg::reg_word_t cmd_register,
    output regex_pkg::reg_word_t status_register,
    output regex_pkg::reg_word_t data_o_register
);
    import regex_pkg::*;

    // ram port
    mem_addr_t    bram_addr;
    mem_raw_t     bram_data_in;
    mem_raw_t     bram_data_out;
    logic         bram_we;
    logic         bram_en;
    mem_payload_t memory_data;

    // matcher handshakes
    logic      core_reset;
    logic      memory_ready;
    logic      memory_valid;
    mem_addr_t memory_addr;
    logic      start_ready;
    logic      start_valid;
    mem_addr_t start_cc_pointer;
    logic      finish;
    logic      accept;

    // matcher sees the word without parity
    assign memory_data = {bram_data_out[16:9], bram_data_out[7:0]};

    regex_host_ctrl u_host_ctrl (
        .clk                       (clk),
        .reset                     (reset),
        .data_in_register          (data_in_register),
        .address_register          (address_register),
        .start_cc_pointer_register (start_cc_pointer_register),
        .cmd_register              (cmd_register),
        .status_register           (status_register),
        .data_o_register           (data_o_register),
        .bram_addr                 (bram_addr),
        .bram_data_in              (bram_data_in),
        .bram_we                   (bram_we),
        .bram_en                   (bram_en),
        .bram_data_out             (bram_data_out),
        .core_reset                (core_reset),
        .memory_ready              (memory_ready),
        .memory_addr               (memory_addr),
        .memory_valid              (memory_valid),
        .start_ready               (start_ready),
        .start_cc_pointer          (start_cc_pointer),
        .start_valid               (start_valid),
        .finish                    (finish),
        .accept                    (accept)
    );

    parity_bram u_bram (
        .clk           (clk),
        .reset         (core_reset),
        .bram_addr     (bram_addr),
        .bram_data_in  (bram_data_in),
        .bram_we       (bram_we),
        .bram_en       (bram_en),
        .bram_data_out (bram_data_out)
    );

    regex_matcher u_matcher (
        .clk              (clk),
        .reset            (core_reset),
        .memory_ready     (memory_ready),
        .memory_addr      (memory_addr),
        .memory_valid     (memory_valid),
        .memory_data      (memory_data),
        .start_ready      (start_ready),
        .start_cc_pointer (start_cc_pointer),
        .start_valid      (start_valid),
        .finish           (finish),
        .accept           (accept)
    );

endmodule

// ==== hdl/regex_host_ctrl.sv ====
`timescale 1ns/1ns

module regex_host_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    // host registers
    input  regex_pkg::reg_word_t data_in_register,
    input  regex_pkg::reg_word_t address_register,
    input  regex_pkg::reg_word_t start_cc_pointer_register,
    input  regex_pkg::reg_word_t cmd_register,
    output regex_pkg::reg_word_t status_register,
    output regex_pkg::reg_word_t data_o_register,
    // ram port
    output regex_pkg::mem_addr_t bram_addr,
    output regex_pkg::mem_raw_t  bram_data_in,
    output logic                 bram_we,
    output logic                 bram_en,
    input  regex_pkg::mem_raw_t  bram_data_out,
    // matcher
    output logic                 core_reset,
    output logic                 memory_ready,
    input  regex_pkg::mem_addr_t memory_addr,
    input  logic                 memory_valid,
    output logic                 start_ready,
    output regex_pkg::mem_addr_t start_cc_pointer,
    input  logic                 start_valid,
    input  logic                 finish,
    input  logic                 accept
);
    import regex_pkg::*;

    reg_word_t    status_next;
    reg_word_t    elapsed, elapsed_next;
    mem_payload_t write_payload;
    mem_payload_t read_payload;
    char_t        write_hi, write_lo;

    assign core_reset = reset || (cmd_register == CMD_RESET);

    ////////////////////
    // parity add and strip

    assign write_payload = data_in_register[MEM_WIDTH-1:0];
    assign write_hi      = write_payload[MEM_WIDTH-1 -: CHARACTER_WIDTH];
    assign write_lo      = write_payload[CHARACTER_WIDTH-1:0];
    // even parity bit sits above each byte
    assign bram_data_in  = {^write_hi, write_hi, ^write_lo, write_lo};
    assign read_payload  = {bram_data_out[16:9], bram_data_out[7:0]};

    ////////////////////
    // status and counter

    always_ff @(posedge clk)
    begin
        if (core_reset)
        begin
            status_register <= STATUS_IDLE;
            elapsed         <= '0;
        end
        else
        begin
            status_register <= status_next;
            elapsed         <= elapsed_next;
        end
    end

    always_comb
    begin
        status_next      = status_register;
        elapsed_next     = elapsed;
        bram_addr        = address_register[MEM_ADDR_WIDTH-1:0];
        bram_en          = 1'b0;
        bram_we          = 1'b0;
        memory_ready     = 1'b0;
        start_ready      = 1'b0;
        start_cc_pointer = '0;

        case (status_register)
            STATUS_IDLE, STATUS_ACCEPTED, STATUS_REJECTED:
            begin
                case (cmd_register)
                    CMD_WRITE:
                    begin
                        // writes again on every held cycle
                        bram_en = 1'b1;
                        bram_we = 1'b1;
                    end
                    CMD_READ:
                    begin
                        bram_en = 1'b1;
                    end
                    CMD_START:
                    begin
                        start_ready      = 1'b1;
                        start_cc_pointer = start_cc_pointer_register[MEM_ADDR_WIDTH-1:0];
                        memory_ready     = 1'b1;
                        bram_addr        = memory_addr;
                        bram_en          = memory_valid;
                        if (start_valid)
                        begin
                            status_next  = STATUS_RUNNING;
                            elapsed_next = '0;
                        end
                    end
                    CMD_NOP, CMD_RESET:
                    begin
                        // port parked
                        bram_en = 1'b0;
                    end
                    default:
                    begin
                        bram_en = 1'b0;
                    end
                endcase
            end
            STATUS_RUNNING:
            begin
                // matcher owns the port
                memory_ready = 1'b1;
                bram_addr    = memory_addr;
                bram_en      = memory_valid;
                if (finish)
                begin
                    status_next = accept ? STATUS_ACCEPTED : STATUS_REJECTED;
                end
                // saturate at all ones
                if (!(&elapsed))
                begin
                    elapsed_next = elapsed + 1'b1;
                end
            end
            default:
            begin
                status_next = STATUS_IDLE;
            end
        endcase
    end

    // read data, or the counter when asked
    always_comb
    begin
        if (cmd_register == CMD_READ_ELAPSED)
        begin
            data_o_register = elapsed;
        end
        else
        begin
            data_o_register = {{(REG_WIDTH-MEM_WIDTH){1'b0}}, read_payload};
        end
    end

endmodule

// ==== hdl/regex_matcher.sv ====
`timescale 1ns/1ns

module regex_matcher (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    memory_ready,
    output regex_pkg::mem_addr_t    memory_addr,
    output logic                    memory_valid,
    input  regex_pkg::mem_payload_t memory_data,
    input  logic                    start_ready,
    input  regex_pkg::mem_addr_t    start_cc_pointer,
    output logic                    start_valid,
    output logic                    finish,
    output logic                    accept
);
    import regex_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH_INSTR,
        ST_WAIT_INSTR,
        ST_FETCH_CHAR,
        ST_WAIT_CHAR,
        ST_DONE
    } state_t;

    state_t       state, state_next;
    pc_t          pc, pc_next;
    mem_addr_t    cc_ptr, cc_ptr_next;
    logic         accept_q, accept_next;
    mem_payload_t instr_q, instr_next;

    mem_addr_t pc_addr;
    char_t     word_op;
    char_t     instr_op;
    char_t     instr_operand;
    char_t     cur_char;
    logic      last_pc;

    // programs live at the bottom of the ram
    assign pc_addr = {{(MEM_ADDR_WIDTH-PC_WIDTH){1'b0}}, pc};

    assign word_op       = memory_data[MEM_WIDTH-1 -: CHARACTER_WIDTH];
    assign instr_op      = instr_q[MEM_WIDTH-1 -: CHARACTER_WIDTH];
    assign instr_operand = instr_q[CHARACTER_WIDTH-1:0];
    // one character per word, low byte
    assign cur_char      = memory_data[CHARACTER_WIDTH-1:0];
    assign last_pc       = &pc;

    ////////////////////
    // next state

    always_comb
    begin
        state_next   = state;
        pc_next      = pc;
        cc_ptr_next  = cc_ptr;
        accept_next  = accept_q;
        instr_next   = instr_q;
        memory_valid = 1'b0;
        memory_addr  = pc_addr;
        start_valid  = 1'b0;
        finish       = 1'b0;
        accept       = 1'b0;

        case (state)
            ST_IDLE:
            begin
                if (start_ready)
                begin
                    start_valid = 1'b1;
                    pc_next     = '0;
                    cc_ptr_next = start_cc_pointer;
                    accept_next = 1'b0;
                    state_next  = ST_FETCH_INSTR;
                end
            end
            ST_FETCH_INSTR:
            begin
                memory_valid = 1'b1;
                memory_addr  = pc_addr;
                if (memory_ready)
                begin
                    state_next = ST_WAIT_INSTR;
                end
            end
            ST_WAIT_INSTR:
            begin
                instr_next = memory_data;
                // accept needs no character
                if (word_op == OP_ACCEPT)
                begin
                    accept_next = 1'b1;
                    state_next  = ST_DONE;
                end
                else
                begin
                    state_next = ST_FETCH_CHAR;
                end
            end
            ST_FETCH_CHAR:
            begin
                memory_valid = 1'b1;
                memory_addr  = cc_ptr;
                if (memory_ready)
                begin
                    state_next = ST_WAIT_CHAR;
                end
            end
            ST_WAIT_CHAR:
            begin
                // reject unless a rule below says otherwise
                accept_next = 1'b0;
                state_next  = ST_DONE;
                case (instr_op)
                    OP_CHAR, OP_ANY:
                    begin
                        if (cur_char != '0 && !last_pc &&
                            (instr_op == OP_ANY || cur_char == instr_operand))
                        begin
                            pc_next     = pc + 1'b1;
                            cc_ptr_next = cc_ptr + 1'b1;
                            state_next  = ST_FETCH_INSTR;
                        end
                    end
                    OP_END:
                    begin
                        accept_next = (cur_char == '0);
                    end
                    default:
                    begin
                        accept_next = 1'b0;
                    end
                endcase
            end
            ST_DONE:
            begin
                finish     = 1'b1;
                accept     = accept_q;
                state_next = ST_IDLE;
            end
            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

    ////////////////////
    // registers

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= ST_IDLE;
            pc       <= '0;
            cc_ptr   <= '0;
            accept_q <= 1'b0;
        end
        else
        begin
            state    <= state_next;
            pc       <= pc_next;
            cc_ptr   <= cc_ptr_next;
            accept_q <= accept_next;
        end
    end

    // current instruction word
    always_ff @(posedge clk)
    begin
        instr_q <= instr_next;
    end

endmodule

// ==== hdl/parity_bram.sv ====
`timescale 1ns/1ns

module parity_bram (
    input  logic                 clk,
    input  logic                 reset,
    input  regex_pkg::mem_addr_t bram_addr,
    input  regex_pkg::mem_raw_t  bram_data_in,
    input  logic                 bram_we,
    input  logic                 bram_en,
    output regex_pkg::mem_raw_t  bram_data_out
);
    import regex_pkg::*;

    mem_raw_t mem [MEM_DEPTH];

    // array write port
    always_ff @(posedge clk)
    begin
        if (bram_en && bram_we)
        begin
            mem[bram_addr] <= bram_data_in;
        end
    end

    // registered read, word appears one cycle after the address
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bram_data_out <= '0;
        end
        else if (bram_en && !bram_we)
        begin
            bram_data_out <= mem[bram_addr];
        end
    end

endmodule

// ==== hdl/regex_pkg.sv ====
package regex_pkg;

    ////////////////////
    // widths

    localparam int REG_WIDTH       = 32;
    localparam int MEM_ADDR_WIDTH  = 11;
    localparam int MEM_RAW_WIDTH   = 18;
    localparam int MEM_WIDTH       = 16;
    localparam int CHARACTER_WIDTH = 8;
    localparam int PC_WIDTH        = 8;
    localparam int MEM_DEPTH       = 2 ** MEM_ADDR_WIDTH;

    typedef logic [REG_WIDTH-1:0]       reg_word_t;
    typedef logic [MEM_ADDR_WIDTH-1:0]  mem_addr_t;
    // byte0, parity0, byte1, parity1 from lsb up
    typedef logic [MEM_RAW_WIDTH-1:0]   mem_raw_t;
    typedef logic [MEM_WIDTH-1:0]       mem_payload_t;
    typedef logic [CHARACTER_WIDTH-1:0] char_t;
    typedef logic [PC_WIDTH-1:0]        pc_t;

    ////////////////////
    // host commands

    localparam reg_word_t CMD_NOP          = 32'd0;
    localparam reg_word_t CMD_WRITE        = 32'd1;
    localparam reg_word_t CMD_READ         = 32'd2;
    localparam reg_word_t CMD_RESET        = 32'd3;
    localparam reg_word_t CMD_START        = 32'd4;
    localparam reg_word_t CMD_READ_ELAPSED = 32'd5;

    // status register values
    localparam reg_word_t STATUS_IDLE     = 32'd0;
    localparam reg_word_t STATUS_RUNNING  = 32'd1;
    localparam reg_word_t STATUS_ACCEPTED = 32'd2;
    localparam reg_word_t STATUS_REJECTED = 32'd3;

    ////////////////////
    // opcodes, upper byte of an instruction word

    localparam char_t OP_CHAR   = 8'd1;
    localparam char_t OP_ANY    = 8'd2;
    localparam char_t OP_ACCEPT = 8'd3;
    localparam char_t OP_END    = 8'd4;

endpackage
